// ==== verilog/text_pkg.sv ====
package text_pkg;

        // Largest grid the field widths allow
        localparam int max_cols = 64;
        localparam int max_rows = 32;

        localparam int col_w  = $clog2(max_cols);       // Cell column field
        localparam int row_w  = $clog2(max_rows);       // Cell row field
        localparam int x_w    = $clog2(max_cols * 8) + 1; // Room for the blank
        localparam int y_w    = $clog2(max_rows * 8) + 1;
        localparam int code_w = 5;

        // 0..25 are letters, the rest draw blank
        typedef logic [code_w-1:0] char_code_t;

        // Bit 7 is the leftmost pixel
        typedef logic [7:0] glyph_row_t;

        typedef struct packed {
                logic [col_w-1:0] col;
                logic [row_w-1:0] row;
                char_code_t       code;
        } char_write_t;

        typedef struct packed {
                logic [x_w-1:0] x;
                logic [y_w-1:0] y;
                logic           active;
        } screen_pos_t;

        typedef struct packed {
                logic pixel;
                logic active;
                logic hsync;
                logic vsync;
        } video_out_t;

endpackage

// ==== verilog/alphabet_font_rom_8.sv ====
`timescale 1ns/1ns

module alphabet_font_rom_8 (
        input  text_pkg::char_code_t char_idx,   // 0..25 for A..Z
        input  logic [2:0]           row,        // 0 is the top scan line
        output text_pkg::glyph_row_t bitmap_row
);

        // Whole glyph with the top line in the high byte
        logic [63:0] glyph;

        always_comb begin
                case (char_idx)
                5'd0:    glyph = 64'h18_24_42_42_7E_42_42_00;  // A
                5'd1:    glyph = 64'h7C_42_42_7C_42_42_7C_00;  // B
                5'd2:    glyph = 64'h3C_42_40_40_40_42_3C_00;  // C
                5'd3:    glyph = 64'h7C_42_42_42_42_42_7C_00;  // D
                5'd4:    glyph = 64'h7E_40_40_7C_40_40_7E_00;  // E
                5'd5:    glyph = 64'h7E_40_40_7C_40_40_40_00;  // F
                5'd6:    glyph = 64'h3C_42_40_4E_42_42_3C_00;  // G
                5'd7:    glyph = 64'h42_42_42_7E_42_42_42_00;  // H
                5'd8:    glyph = 64'h3C_18_18_18_18_18_3C_00;  // I
                5'd9:    glyph = 64'h1E_04_04_04_44_44_38_00;  // J
                5'd10:   glyph = 64'h42_44_48_70_48_44_42_42;  // K
                5'd11:   glyph = 64'h40_40_40_40_40_40_40_7E;  // L
                5'd12:   glyph = 64'h42_66_5A_42_42_42_42_42;  // M
                5'd13:   glyph = 64'h42_62_52_4A_46_42_42_42;  // N
                5'd14:   glyph = 64'h3C_42_42_42_42_42_42_3C;  // O
                5'd15:   glyph = 64'h7C_42_42_7C_40_40_40_40;  // P
                5'd16:   glyph = 64'h3C_42_42_42_4A_44_3A_02;  // Q
                5'd17:   glyph = 64'h7C_42_42_7C_48_44_42_42;  // R
                5'd18:   glyph = 64'h3C_42_40_3C_02_02_42_3C;  // S
                5'd19:   glyph = 64'h7E_18_18_18_18_18_18_18;  // T
                5'd20:   glyph = 64'h42_42_42_42_42_42_42_3C;  // U
                5'd21:   glyph = 64'h42_42_42_42_42_24_24_18;  // V
                5'd22:   glyph = 64'h42_42_42_42_5A_5A_66_42;  // W
                5'd23:   glyph = 64'h42_24_24_18_18_24_24_42;  // X
                5'd24:   glyph = 64'h42_24_24_18_18_18_18_18;  // Y
                5'd25:   glyph = 64'h7E_02_04_08_10_20_40_7E;  // Z
                default: glyph = '0;                           // Blank cell
                endcase
        end

        // Row r sits at bit offset 8 * (7 - r)
        assign bitmap_row = glyph[{~row, 3'b000} +: 8];

endmodule

// ==== verilog/text_buffer.sv ====
`timescale 1ns/1ns

module text_buffer #(
        parameter int cols = 16,
        parameter int rows = 4
) (
        input  logic                       clk,
        input  logic                       char_we,
        input  text_pkg::char_write_t      char_wr,
        input  logic [text_pkg::col_w-1:0] rd_col,
        input  logic [text_pkg::row_w-1:0] rd_row,
        output text_pkg::char_code_t       rd_code
);
        import text_pkg::*;

        // Index widths for the configured grid
        localparam int col_aw = (cols > 1) ? $clog2(cols) : 1;
        localparam int row_aw = (rows > 1) ? $clog2(rows) : 1;

        char_code_t       mem [rows][cols];
        logic [col_aw-1:0] wr_c;
        logic [row_aw-1:0] wr_r;
        logic [col_aw-1:0] rd_c;
        logic [row_aw-1:0] rd_r;

        assign wr_c = char_wr.col[col_aw-1:0];
        assign wr_r = char_wr.row[row_aw-1:0];
        assign rd_c = rd_col[col_aw-1:0];
        assign rd_r = rd_row[row_aw-1:0];

        always_ff @(posedge clk) begin
                if (char_we)
                        mem[wr_r][wr_c] <= char_wr.code;
                // Same-cell read in the write cycle sees the old code
                rd_code <= mem[rd_r][rd_c];
        end

endmodule

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ns

module video_timing #(
        parameter int cols    = 16,
        parameter int rows    = 4,
        parameter int h_blank = 16,
        parameter int v_blank = 4
) (
        input  logic                  clk,
        input  logic                  reset,
        output text_pkg::screen_pos_t pos,
        output logic                  hsync,
        output logic                  vsync
);
        import text_pkg::*;

        // Active extents and the last count of each axis
        localparam logic [x_w-1:0] h_active = x_w'(cols * 8);
        localparam logic [x_w-1:0] h_last   = x_w'(cols * 8 + h_blank - 1);
        localparam logic [y_w-1:0] v_active = y_w'(rows * 8);
        localparam logic [y_w-1:0] v_last   = y_w'(rows * 8 + v_blank - 1);

        logic [x_w-1:0] x;
        logic [y_w-1:0] y;
        logic           line_end;
        logic           frame_end;
        logic           h_blanking;
        logic           v_blanking;

        assign line_end  = (x == h_last);
        assign frame_end = (y == v_last);

        always_ff @(posedge clk) begin
                if (reset) begin
                        x <= '0;
                        y <= '0;
                end else begin
                        if (line_end) begin
                                x <= '0;
                                y <= frame_end ? '0 : y + 1'b1;
                        end else begin
                                x <= x + 1'b1;
                        end
                end
        end

        assign h_blanking = (x >= h_active);
        assign v_blanking = (y >= v_active);

        assign pos.x      = x;
        assign pos.y      = y;
        assign pos.active = !h_blanking && !v_blanking;

        // Sync levels span the whole blank on each axis
        assign hsync = h_blanking;
        assign vsync = v_blanking;

endmodule

// ==== verilog/glyph_renderer.sv ====
`timescale 1ns/1ns

module glyph_renderer #(
        parameter int cols = 16,
        parameter int rows = 4
) (
        input  logic                       clk,
        input  logic                       reset,
        input  text_pkg::screen_pos_t      pos,
        input  logic                       hsync,
        input  logic                       vsync,
        output logic [text_pkg::col_w-1:0] rd_col,
        output logic [text_pkg::row_w-1:0] rd_row,
        input  text_pkg::char_code_t       rd_code,
        output text_pkg::video_out_t       video
);
        import text_pkg::*;

        localparam logic [col_w-1:0] last_col = col_w'(cols - 1);
        localparam logic [row_w-1:0] last_row = row_w'(rows - 1);

        typedef struct packed {
                logic valid;
                logic active;
                logic hsync;
                logic vsync;
        } stage_ctl_t;

        logic [col_w-1:0] cell_col;
        logic [row_w-1:0] cell_row;

        stage_ctl_t s1_ctl;
        stage_ctl_t s2_ctl;
        stage_ctl_t s3_ctl;
        logic [2:0] s1_xoff;
        logic [2:0] s1_yoff;
        logic [2:0] s2_xoff;
        glyph_row_t font_row;
        glyph_row_t s2_row;
        logic       s3_pixel;

        // Cell address and in-glyph offset
        assign cell_col = pos.x[3 +: col_w];
        assign cell_row = pos.y[3 +: row_w];

        // Keep blank-area reads inside the grid
        assign rd_col = (cell_col > last_col) ? '0 : cell_col;
        assign rd_row = (cell_row > last_row) ? '0 : cell_row;

        alphabet_font_rom_8 u_font (
                .char_idx   (rd_code),
                .row        (s1_yoff),
                .bitmap_row (font_row)
        );

        always_ff @(posedge clk) begin
                if (reset) begin
                        s1_ctl   <= '0;
                        s2_ctl   <= '0;
                        s3_ctl   <= '0;
                        s3_pixel <= 1'b0;
                end else begin
                        s1_ctl   <= '{valid: 1'b1, active: pos.active,
                                      hsync: hsync, vsync: vsync};
                        s2_ctl   <= s1_ctl;     // Buffer code is ready alongside s1
                        s3_ctl   <= s2_ctl;
                        s3_pixel <= s2_ctl.valid && s2_ctl.active && s2_row[3'd7 - s2_xoff];
                end
        end

        always_ff @(posedge clk) begin
                s1_xoff <= pos.x[2:0];
                s1_yoff <= pos.y[2:0];
                s2_xoff <= s1_xoff;
                s2_row  <= font_row;
        end

        assign video.pixel  = s3_pixel;
        assign video.active = s3_ctl.valid && s3_ctl.active;
        assign video.hsync  = s3_ctl.hsync;
        assign video.vsync  = s3_ctl.vsync;

endmodule

// ==== verilog/text_display.sv ====
`timescale 1ns/1ns

module text_display #(
        parameter int cols    = 16,
        parameter int rows    = 4,
        parameter int h_blank = 16,
        parameter int v_blank = 4
) (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  char_we,
        input  text_pkg::char_write_t char_wr,
        output text_pkg::video_out_t  video
);
        import text_pkg::*;

        screen_pos_t      pos;
        logic             hsync;
        logic             vsync;
        logic [col_w-1:0] rd_col;
        logic [row_w-1:0] rd_row;
        char_code_t       rd_code;

        // Raster sweep
        video_timing #(
                .cols    (cols),
                .rows    (rows),
                .h_blank (h_blank),
                .v_blank (v_blank)
        ) u_timing (
                .clk   (clk),
                .reset (reset),
                .pos   (pos),
                .hsync (hsync),
                .vsync (vsync)
        );

        text_buffer #(
                .cols (cols),
                .rows (rows)
        ) u_buffer (
                .clk     (clk),
                .char_we (char_we),     // Host write goes straight in
                .char_wr (char_wr),
                .rd_col  (rd_col),
                .rd_row  (rd_row),
                .rd_code (rd_code)
        );

        // Three cycles from position to pixel
        glyph_renderer #(
                .cols (cols),
                .rows (rows)
        ) u_renderer (
                .clk     (clk),
                .reset   (reset),
                .pos     (pos),
                .hsync   (hsync),
                .vsync   (vsync),
                .rd_col  (rd_col),
                .rd_row  (rd_row),
                .rd_code (rd_code),
                .video   (video)
        );

endmodule

// ==== tb/tb_text_display.sv ====
`timescale 1ns/1ns

module tb_text_display;
        import text_pkg::*;

        localparam int n_cols      = 16;
        localparam int n_rows      = 4;
        localparam int h_blank     = 16;
        localparam int v_blank     = 4;
        localparam int h_act       = n_cols * 8;
        localparam int v_act       = n_rows * 8;
        localparam int line_len    = h_act + h_blank;
        localparam int frame_lines = v_act + v_blank;
        localparam int frame_len   = line_len * frame_lines;
        localparam int max_lines   = 64;

        localparam char_code_t code_a     = 5'd0;
        localparam char_code_t code_k     = 5'd10;
        localparam char_code_t code_t     = 5'd19;
        localparam char_code_t code_z     = 5'd25;
        localparam char_code_t code_blank = 5'd31;

        logic        clk;
        logic        reset;
        logic        char_we;
        char_write_t char_wr;
        video_out_t  video;

        // Reference glyphs with the top row first and the MSB as the left pixel
        glyph_row_t glyph_a [8] = '{8'h18, 8'h24, 8'h42, 8'h42, 8'h7E, 8'h42, 8'h42, 8'h00};
        glyph_row_t glyph_k [8] = '{8'h42, 8'h44, 8'h48, 8'h70, 8'h48, 8'h44, 8'h42, 8'h42};
        glyph_row_t glyph_t [8] = '{8'h7E, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18};
        glyph_row_t glyph_z [8] = '{8'h7E, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h7E};

        char_code_t exp_code [n_rows][n_cols];  // Shadow of the text buffer
        logic       frame_pix [v_act * h_act];  // One bit per active sample
        int         line_active [max_lines];
        int         line_hsync [max_lines];
        int         line_vsync [max_lines];
        int         lines_seen;
        int         active_seen;
        integer     seed;

        text_display #(
                .cols    (n_cols),
                .rows    (n_rows),
                .h_blank (h_blank),
                .v_blank (v_blank)
        ) UUT (
                .clk     (clk),
                .reset   (reset),
                .char_we (char_we),
                .char_wr (char_wr),
                .video   (video)
        );

        always #10 clk = ~clk;

        task automatic fail_now(input string msg);
                $display("%s", msg);
                $display("Something failed");
                $fatal(1, "Stopped at first error");
        endtask

        task automatic compare_video(input string test, input video_out_t exp,
                                     input video_out_t act);
                if (act !== exp)
                        fail_now($sformatf("ERROR %s: expected %b actual %b", test, exp, act));
        endtask

        task automatic compare_row(input string test, input glyph_row_t exp,
                                   input glyph_row_t act);
                if (act !== exp)
                        fail_now($sformatf("ERROR %s: expected %h actual %h", test, exp, act));
        endtask

        task automatic compare_count(input string test, input int exp, input int act);
                if (act != exp)
                        fail_now($sformatf("ERROR %s: expected %0d actual %0d", test, exp, act));
        endtask

        function automatic glyph_row_t expected_row(input char_code_t code, input int k);
                case (code)
                code_a:  return glyph_a[k];
                code_k:  return glyph_k[k];
                code_t:  return glyph_t[k];
                code_z:  return glyph_z[k];
                default: return '0;             // Codes 26..31 draw nothing
                endcase
        endfunction

        function automatic glyph_row_t captured_row(input int col, input int row, input int k);
                glyph_row_t bits;
                int         base;
                base = (row * 8 + k) * h_act + col * 8;
                for (int i = 0; i < 8; i++)
                        bits[7 - i] = frame_pix[base + i];
                return bits;
        endfunction

        task automatic write_char(input int col, input int row, input char_code_t code);
                char_write_t cmd;
                cmd.col  = col_w'(col);
                cmd.row  = row_w'(row);
                cmd.code = code;
                @(negedge clk);
                char_we = 1'b1;
                char_wr = cmd;
                @(negedge clk);
                char_we = 1'b0;
                exp_code[row][col] = code;
        endtask

        task automatic capture_frame(input string test);
                video_out_t v;
                video_out_t prev;
                int         waited;
                int         samples;
                int         line;
                int         act_line;
                int         hs_line;
                int         vs_line;
                bit         done;

                // Flush writes already issued through the pipeline
                repeat (4) @(negedge clk);
                prev   = video;
                v      = video;
                waited = 0;
                done   = 1'b0;
                while (!done) begin
                        @(negedge clk);
                        v = video;
                        waited++;
                        if (prev.vsync && !v.vsync)
                                done = 1'b1;
                        else if (waited > 2 * frame_len)
                                fail_now($sformatf("%s: vsync never fell", test));
                        prev = v;
                end

                // v now holds the first sample of the frame
                line        = 0;
                act_line    = 0;
                hs_line     = 0;
                vs_line     = 0;
                samples     = 0;
                active_seen = 0;
                done        = 1'b0;
                while (!done) begin
                        if (v.active) begin
                                if (active_seen < v_act * h_act)
                                        frame_pix[active_seen] = v.pixel;
                                active_seen++;
                                act_line++;
                        end else if (v.pixel !== 1'b0) begin
                                fail_now($sformatf("%s: pixel set outside the active area", test));
                        end
                        if (v.hsync)
                                hs_line++;
                        if (v.vsync)
                                vs_line++;
                        prev = v;
                        @(negedge clk);
                        v = video;
                        samples++;
                        if (prev.hsync && !v.hsync) begin       // Line closes as hsync drops
                                if (line < max_lines) begin
                                        line_active[line] = act_line;
                                        line_hsync[line]  = hs_line;
                                        line_vsync[line]  = vs_line;
                                end
                                line++;
                                act_line = 0;
                                hs_line  = 0;
                                vs_line  = 0;
                        end
                        if (prev.vsync && !v.vsync)
                                done = 1'b1;
                        else if (samples > 2 * frame_len)
                                fail_now($sformatf("%s: frame did not end", test));
                end
                lines_seen = line;
        endtask

        // Capture a frame and compare every cell against the shadow buffer
        task automatic check_screen(input string test);
                capture_frame(test);
                compare_count({test, " lines"}, frame_lines, lines_seen);
                compare_count({test, " active samples"}, v_act * h_act, active_seen);
                for (int r = 0; r < n_rows; r++) begin
                        for (int c = 0; c < n_cols; c++) begin
                                for (int k = 0; k < 8; k++) begin
                                        compare_row($sformatf("%s cell %0d,%0d row %0d",
                                                              test, c, r, k),
                                                    expected_row(exp_code[r][c], k),
                                                    captured_row(c, r, k));
                                end
                        end
                end
        endtask

        task automatic test_reset();
                video_out_t zero;
                int         cycles;
                bit         seen;
                zero  = '0;
                reset = 1'b1;
                repeat (16) begin
                        @(negedge clk);
                        compare_video("reset", zero, video);
                end
                reset  = 1'b0;
                cycles = 0;
                seen   = 1'b0;
                while (!seen) begin
                        @(negedge clk);
                        cycles++;
                        if (video.active)
                                seen = 1'b1;
                        else if (cycles > 8)
                                fail_now("reset: no active sample after reset release");
                        else
                                compare_video("reset release", zero, video);
                end
                compare_count("reset latency", 3, cycles);      // Three pipeline stages
        endtask

        task automatic test_geometry();
                capture_frame("geometry");
                compare_count("geometry lines", frame_lines, lines_seen);
                compare_count("geometry active samples", v_act * h_act, active_seen);
                for (int l = 0; l < frame_lines; l++) begin
                        compare_count($sformatf("geometry line %0d active", l),
                                      (l < v_act) ? h_act : 0, line_active[l]);
                        compare_count($sformatf("geometry line %0d hsync", l),
                                      h_blank, line_hsync[l]);
                        compare_count($sformatf("geometry line %0d vsync", l),
                                      (l < v_act) ? 0 : line_len, line_vsync[l]);
                end
        endtask

        task automatic test_blank();
                for (int r = 0; r < n_rows; r++)
                        for (int c = 0; c < n_cols; c++)
                                write_char(c, r, code_blank);
                check_screen("blank");
        endtask

        task automatic test_glyphs();
                write_char(0, 0, code_a);               // Corners
                write_char(n_cols - 1, 0, code_k);
                write_char(0, n_rows - 1, code_t);
                write_char(n_cols - 1, n_rows - 1, code_z);
                write_char(7, 1, code_k);               // Middle
                write_char(8, 2, code_z);
                check_screen("glyphs");
        endtask

        task automatic test_random();
                int         col;
                int         row;
                int         pick;
                char_code_t code;
                for (int i = 0; i < 24; i++) begin
                        col  = ($random(seed) & 32'h7fff_ffff) % n_cols;
                        row  = ($random(seed) & 32'h7fff_ffff) % n_rows;
                        pick = ($random(seed) & 32'h7fff_ffff) % 8;
                        case (pick)
                        0:       code = code_a;
                        1:       code = code_t;
                        default: code = char_code_t'(24 + pick);        // 26..31
                        endcase
                        write_char(col, row, code);
                end
                check_screen("live update");
        endtask

        initial begin
                clk     = 1'b0;
                reset   = 1'b1;
                char_we = 1'b0;
                char_wr = '0;
                seed    = 32'h3ce3038e;

                test_reset();
                test_geometry();
                test_blank();
                test_glyphs();
                test_random();

                $display("Everything OK");
                $finish;
        end

endmodule

// ==== sim.f ====
verilog/text_pkg.sv
verilog/alphabet_font_rom_8.sv
verilog/text_buffer.sv
verilog/video_timing.sv
verilog/glyph_renderer.sv
verilog/text_display.sv
tb/tb_text_display.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f sim.f --top-module tb_text_display -o tb_sim > build.log 2>&1 \
        && ./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Everything OK" sim.log \
        && { echo "Simulation passed"; exit 0; } \
        || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
